//--- verilog/checkpoint_pkg.sv
// sizes, threshold and vector types for the rename checkpoint array
`default_nettype none

package checkpoint_pkg;

	// ----------------------------------------
	// rename map table
	localparam int AR_COUNT = 8;
	localparam int LOG_PR_COUNT = 6;
	localparam int MAP_TABLE_WIDTH = AR_COUNT * LOG_PR_COUNT;

	// ----------------------------------------
	// branch predictor state
	localparam int LH_LENGTH = 8;
	localparam int GH_LENGTH = 12;
	localparam int RAS_INDEX_WIDTH = 3;

	// ----------------------------------------
	// checkpoint slots
	localparam int CHECKPOINT_COUNT = 8;
	localparam int CHECKPOINT_INDEX_WIDTH = 3;
	// low-confidence branches may checkpoint only above this many free slots
	localparam int CHECKPOINT_THRESHOLD = 3;
	// wide enough to hold 0 through CHECKPOINT_COUNT
	localparam int FREE_COUNT_WIDTH = 4;

	// register r holds its physical tag at bits r*LOG_PR_COUNT upward
	typedef logic [MAP_TABLE_WIDTH-1:0] map_table_t;

	typedef logic [LH_LENGTH-1:0] lh_t;
	typedef logic [GH_LENGTH-1:0] gh_t;
	typedef logic [RAS_INDEX_WIDTH-1:0] ras_index_t;

	typedef logic [CHECKPOINT_INDEX_WIDTH-1:0] checkpoint_index_t;
	typedef logic [FREE_COUNT_WIDTH-1:0] free_count_t;

endpackage

`default_nettype wire

//--- verilog/checkpoint_alloc.sv
// slot valid bits, lowest free slot search, free count and threshold flag
`default_nettype none

module checkpoint_alloc (
	input logic CLK,
	input logic nRST,

	// save request from the front end
	input logic save_valid,
	output logic save_ready,
	output checkpoint_pkg::checkpoint_index_t save_index,
	output logic save_write,

	// branch resolved, slot can be freed
	input logic clear_valid,
	input checkpoint_pkg::checkpoint_index_t clear_index,

	output logic above_threshold
);

	import checkpoint_pkg::*;

	// one bit per slot, set while the slot holds a live checkpoint
	logic [CHECKPOINT_COUNT-1:0] slot_valid;
	logic [CHECKPOINT_COUNT-1:0] slot_valid_next;
	free_count_t free_count;

	// ----------------------------------------
	// lowest free slot
	// walk downward so the lowest free index is the last one written
	always_comb begin
		save_ready = 1'b0;
		save_index = '0;
		for (int i = CHECKPOINT_COUNT - 1; i >= 0; i--) begin
			if (!slot_valid[i]) begin
				save_ready = 1'b1;
				save_index = checkpoint_index_t'(i);
			end
		end
	end

	// full array drops the strobe
	assign save_write = save_valid & save_ready;

	// ----------------------------------------
	// free count and threshold
	always_comb begin
		free_count = '0;
		for (int i = 0; i < CHECKPOINT_COUNT; i++) begin
			if (!slot_valid[i]) begin
				free_count = free_count + 1'b1;
			end
		end
	end

	assign above_threshold = free_count > free_count_t'(CHECKPOINT_THRESHOLD);

	// ----------------------------------------
	// valid bit update
	// a save only lands on a free slot, so clear first then set
	always_comb begin
		slot_valid_next = slot_valid;
		if (clear_valid) begin
			slot_valid_next[clear_index] = 1'b0;
		end
		if (save_write) begin
			slot_valid_next[save_index] = 1'b1;
		end
	end

	always_ff @(posedge CLK, negedge nRST) begin
		if (~nRST) begin
			slot_valid <= '0;
		end
		else begin
			slot_valid <= slot_valid_next;
		end
	end

endmodule

`default_nettype wire

//--- verilog/checkpoint_storage.sv
// snapshot array with one write port and separate map table and branch info read ports
`default_nettype none

module checkpoint_storage (
	input logic CLK,

	// snapshot write
	input logic write,
	input checkpoint_pkg::checkpoint_index_t write_index,
	input checkpoint_pkg::map_table_t write_map_table,
	input checkpoint_pkg::lh_t write_LH,
	input checkpoint_pkg::gh_t write_GH,
	input checkpoint_pkg::ras_index_t write_ras_index,

	// read indices, one per restore port
	input checkpoint_pkg::checkpoint_index_t map_table_read_index,
	input checkpoint_pkg::checkpoint_index_t branch_info_read_index,

	output checkpoint_pkg::map_table_t read_map_table,
	output checkpoint_pkg::lh_t read_LH,
	output checkpoint_pkg::gh_t read_GH,
	output checkpoint_pkg::ras_index_t read_ras_index
);

	import checkpoint_pkg::*;

	// ----------------------------------------
	// snapshot entries
	map_table_t map_table_entry [CHECKPOINT_COUNT];
	lh_t lh_entry [CHECKPOINT_COUNT];
	gh_t gh_entry [CHECKPOINT_COUNT];
	ras_index_t ras_index_entry [CHECKPOINT_COUNT];

	// one snapshot per slot, written at the allocated index
	always_ff @(posedge CLK) begin
		if (write) begin
			map_table_entry[write_index] <= write_map_table;
			lh_entry[write_index] <= write_LH;
			gh_entry[write_index] <= write_GH;
			ras_index_entry[write_index] <= write_ras_index;
		end
	end

	// ----------------------------------------
	// restore reads
	// map table and branch info may come from different slots
	assign read_map_table = map_table_entry[map_table_read_index];

	assign read_LH = lh_entry[branch_info_read_index];
	assign read_GH = gh_entry[branch_info_read_index];
	assign read_ras_index = ras_index_entry[branch_info_read_index];

endmodule

`default_nettype wire

//--- verilog/checkpoint_array.sv
// allocator and snapshot storage joined into the checkpoint array
`default_nettype none

module checkpoint_array (
	input logic CLK,
	input logic nRST,

	// checkpoint save
	input logic save_valid,
	input checkpoint_pkg::map_table_t save_map_table,
	input checkpoint_pkg::lh_t save_LH,
	input checkpoint_pkg::gh_t save_GH,
	input checkpoint_pkg::ras_index_t save_ras_index,
	output logic save_ready,
	output checkpoint_pkg::checkpoint_index_t save_index,

	// map table restore
	input checkpoint_pkg::checkpoint_index_t map_table_restore_index,
	output checkpoint_pkg::map_table_t map_table_restore_map_table,

	// branch info restore
	input checkpoint_pkg::checkpoint_index_t branch_info_restore_index,
	output checkpoint_pkg::lh_t branch_info_restore_LH,
	output checkpoint_pkg::gh_t branch_info_restore_GH,
	output checkpoint_pkg::ras_index_t branch_info_restore_ras_index,

	// checkpoint clear
	input logic clear_valid,
	input checkpoint_pkg::checkpoint_index_t clear_index,

	output logic above_threshold
);

	// accepted save, writes the slot the allocator picked
	logic save_write;

	checkpoint_alloc u_checkpoint_alloc (
		.CLK(CLK),
		.nRST(nRST),
		.save_valid(save_valid),
		.save_ready(save_ready),
		.save_index(save_index),
		.save_write(save_write),
		.clear_valid(clear_valid),
		.clear_index(clear_index),
		.above_threshold(above_threshold)
	);

	checkpoint_storage u_checkpoint_storage (
		.CLK(CLK),
		.write(save_write),
		.write_index(save_index),
		.write_map_table(save_map_table),
		.write_LH(save_LH),
		.write_GH(save_GH),
		.write_ras_index(save_ras_index),
		.map_table_read_index(map_table_restore_index),
		.branch_info_read_index(branch_info_restore_index),
		.read_map_table(map_table_restore_map_table),
		.read_LH(branch_info_restore_LH),
		.read_GH(branch_info_restore_GH),
		.read_ras_index(branch_info_restore_ras_index)
	);

endmodule

`default_nettype wire

//--- verilog/checkpoint_array_wrapper.sv
// top level with one register stage on every input and output of the checkpoint array
`default_nettype none

module checkpoint_array_wrapper (
	input logic CLK,
	input logic nRST,

	// checkpoint save
	input logic next_save_valid,
	input checkpoint_pkg::map_table_t next_save_map_table,
	input checkpoint_pkg::lh_t next_save_LH,
	input checkpoint_pkg::gh_t next_save_GH,
	input checkpoint_pkg::ras_index_t next_save_ras_index,
	output logic last_save_ready,
	output checkpoint_pkg::checkpoint_index_t last_save_index,

	// map table restore
	input checkpoint_pkg::checkpoint_index_t next_map_table_restore_index,
	output checkpoint_pkg::map_table_t last_map_table_restore_map_table,

	// branch info restore
	input checkpoint_pkg::checkpoint_index_t next_branch_info_restore_index,
	output checkpoint_pkg::lh_t last_branch_info_restore_LH,
	output checkpoint_pkg::gh_t last_branch_info_restore_GH,
	output checkpoint_pkg::ras_index_t last_branch_info_restore_ras_index,

	// checkpoint clear
	input logic next_clear_valid,
	input checkpoint_pkg::checkpoint_index_t next_clear_index,

	output logic last_above_threshold
);

	import checkpoint_pkg::*;

	// ----------------------------------------
	// array side of the register stages
	logic save_valid;
	map_table_t save_map_table;
	lh_t save_LH;
	gh_t save_GH;
	ras_index_t save_ras_index;
	logic save_ready;
	checkpoint_index_t save_index;

	checkpoint_index_t map_table_restore_index;
	map_table_t map_table_restore_map_table;

	checkpoint_index_t branch_info_restore_index;
	lh_t branch_info_restore_LH;
	gh_t branch_info_restore_GH;
	ras_index_t branch_info_restore_ras_index;

	logic clear_valid;
	checkpoint_index_t clear_index;

	logic above_threshold;

	checkpoint_array u_checkpoint_array (
		.CLK(CLK),
		.nRST(nRST),
		.save_valid(save_valid),
		.save_map_table(save_map_table),
		.save_LH(save_LH),
		.save_GH(save_GH),
		.save_ras_index(save_ras_index),
		.save_ready(save_ready),
		.save_index(save_index),
		.map_table_restore_index(map_table_restore_index),
		.map_table_restore_map_table(map_table_restore_map_table),
		.branch_info_restore_index(branch_info_restore_index),
		.branch_info_restore_LH(branch_info_restore_LH),
		.branch_info_restore_GH(branch_info_restore_GH),
		.branch_info_restore_ras_index(branch_info_restore_ras_index),
		.clear_valid(clear_valid),
		.clear_index(clear_index),
		.above_threshold(above_threshold)
	);

	// ----------------------------------------
	// input and output registers
	// strobes come out of reset inactive, everything else zeroed too
	always_ff @(posedge CLK, negedge nRST) begin
		if (~nRST) begin
			save_valid <= 1'b0;
			save_map_table <= '0;
			save_LH <= '0;
			save_GH <= '0;
			save_ras_index <= '0;
			map_table_restore_index <= '0;
			branch_info_restore_index <= '0;
			clear_valid <= 1'b0;
			clear_index <= '0;

			last_save_ready <= 1'b0;
			last_save_index <= '0;
			last_map_table_restore_map_table <= '0;
			last_branch_info_restore_LH <= '0;
			last_branch_info_restore_GH <= '0;
			last_branch_info_restore_ras_index <= '0;
			last_above_threshold <= 1'b0;
		end
		else begin
			// inputs
			save_valid <= next_save_valid;
			save_map_table <= next_save_map_table;
			save_LH <= next_save_LH;
			save_GH <= next_save_GH;
			save_ras_index <= next_save_ras_index;
			map_table_restore_index <= next_map_table_restore_index;
			branch_info_restore_index <= next_branch_info_restore_index;
			clear_valid <= next_clear_valid;
			clear_index <= next_clear_index;

			// outputs
			last_save_ready <= save_ready;
			last_save_index <= save_index;
			last_map_table_restore_map_table <= map_table_restore_map_table;
			last_branch_info_restore_LH <= branch_info_restore_LH;
			last_branch_info_restore_GH <= branch_info_restore_GH;
			last_branch_info_restore_ras_index <= branch_info_restore_ras_index;
			last_above_threshold <= above_threshold;
		end
	end

endmodule

`default_nettype wire

//--- testbench/checkpoint_tb_tasks.svh
// xorshift generator, input drive tasks and typed compare tasks for the checkpoint array testbench
`ifndef CHECKPOINT_TB_TASKS_SVH
`define CHECKPOINT_TB_TASKS_SVH

// ----------------------------------------
// stimulus
function automatic logic [31:0] xorshift(input logic [31:0] x);
	logic [31:0] y;
	y = x ^ (x << 13);
	y = y ^ (y >> 17);
	y = y ^ (y << 5);
	return y;
endfunction

// strobes low, indices at slot 0
task automatic idle_inputs();
	next_save_valid = 1'b0;
	next_save_map_table = '0;
	next_save_LH = '0;
	next_save_GH = '0;
	next_save_ras_index = '0;
	next_map_table_restore_index = '0;
	next_branch_info_restore_index = '0;
	next_clear_valid = 1'b0;
	next_clear_index = '0;
endtask

// one-cycle save and clear strobes, returns once the last_ outputs have settled
task automatic pulse_strobes(input logic save, input logic clear, input checkpoint_index_t idx);
	next_save_valid = save;
	next_save_map_table = snap_map;
	next_save_LH = snap_lh;
	next_save_GH = snap_gh;
	next_save_ras_index = snap_ras;
	next_clear_valid = clear;
	next_clear_index = idx;
	@(negedge CLK);
	next_save_valid = 1'b0;
	next_clear_valid = 1'b0;
	// array updates one edge later, status registered one more
	repeat (2) @(negedge CLK);
endtask

// restore data shows up two edges after the index
task automatic drive_restore(input checkpoint_index_t mt_idx, input checkpoint_index_t bi_idx);
	next_map_table_restore_index = mt_idx;
	next_branch_info_restore_index = bi_idx;
	repeat (2) @(negedge CLK);
endtask

// ----------------------------------------
// typed compares
task automatic check_index(input checkpoint_index_t actual, input checkpoint_index_t expected,
	input string what);
	if (actual !== expected) begin
		$display("Fail at %0t: %s, got %0d, expected %0d", $time, what, actual, expected);
		stop_run();
	end
endtask

task automatic check_map_table(input map_table_t actual, input map_table_t expected,
	input string what);
	if (actual !== expected) begin
		$display("Fail at %0t: %s, got %0h, expected %0h", $time, what, actual, expected);
		stop_run();
	end
endtask

task automatic check_lh(input lh_t actual, input lh_t expected, input string what);
	if (actual !== expected) begin
		$display("Fail at %0t: %s, got %0h, expected %0h", $time, what, actual, expected);
		stop_run();
	end
endtask

task automatic check_gh(input gh_t actual, input gh_t expected, input string what);
	if (actual !== expected) begin
		$display("Fail at %0t: %s, got %0h, expected %0h", $time, what, actual, expected);
		stop_run();
	end
endtask

task automatic check_ras(input ras_index_t actual, input ras_index_t expected, input string what);
	if (actual !== expected) begin
		$display("Fail at %0t: %s, got %0d, expected %0d", $time, what, actual, expected);
		stop_run();
	end
endtask

task automatic check_flag(input logic actual, input logic expected, input string what);
	if (actual !== expected) begin
		$display("Fail at %0t: %s, got %b, expected %b", $time, what, actual, expected);
		stop_run();
	end
endtask

`endif

//--- testbench/checkpoint_array_tb.sv
// testbench for the checkpoint array: clock, reset, DUT, watchdog, reference model, directed tests
`default_nettype none

module checkpoint_array_tb;

	import checkpoint_pkg::*;

	localparam int CLK_PERIOD = 40;
	// tests take about 100 cycles
	localparam int WATCHDOG_CYCLES = 400;
	localparam logic [31:0] SEED = 32'hefa4_c2f6;

	logic CLK;
	logic nRST;
	logic next_save_valid;
	map_table_t next_save_map_table;
	lh_t next_save_LH;
	gh_t next_save_GH;
	ras_index_t next_save_ras_index;
	checkpoint_index_t next_map_table_restore_index;
	checkpoint_index_t next_branch_info_restore_index;
	logic next_clear_valid;
	checkpoint_index_t next_clear_index;
	logic last_save_ready;
	checkpoint_index_t last_save_index;
	map_table_t last_map_table_restore_map_table;
	lh_t last_branch_info_restore_LH;
	gh_t last_branch_info_restore_GH;
	ras_index_t last_branch_info_restore_ras_index;
	logic last_above_threshold;

	// ----------------------------------------
	// reference model and current snapshot
	map_table_t model_map [CHECKPOINT_COUNT];
	lh_t model_lh [CHECKPOINT_COUNT];
	gh_t model_gh [CHECKPOINT_COUNT];
	ras_index_t model_ras [CHECKPOINT_COUNT];
	logic [CHECKPOINT_COUNT-1:0] model_busy;
	logic [31:0] rng_state;
	map_table_t snap_map;
	lh_t snap_lh;
	gh_t snap_gh;
	ras_index_t snap_ras;

	checkpoint_array_wrapper u_checkpoint_array_wrapper (
		.CLK(CLK),
		.nRST(nRST),
		.next_save_valid(next_save_valid),
		.next_save_map_table(next_save_map_table),
		.next_save_LH(next_save_LH),
		.next_save_GH(next_save_GH),
		.next_save_ras_index(next_save_ras_index),
		.last_save_ready(last_save_ready),
		.last_save_index(last_save_index),
		.next_map_table_restore_index(next_map_table_restore_index),
		.last_map_table_restore_map_table(last_map_table_restore_map_table),
		.next_branch_info_restore_index(next_branch_info_restore_index),
		.last_branch_info_restore_LH(last_branch_info_restore_LH),
		.last_branch_info_restore_GH(last_branch_info_restore_GH),
		.last_branch_info_restore_ras_index(last_branch_info_restore_ras_index),
		.next_clear_valid(next_clear_valid),
		.next_clear_index(next_clear_index),
		.last_above_threshold(last_above_threshold)
	);

	task automatic stop_run();
		$display("Verification failed");
		$fatal(1, "simulation stopped on error");
	endtask

	`include "checkpoint_tb_tasks.svh"

	initial begin
		CLK = 1'b0;
		forever #(CLK_PERIOD / 2) CLK = ~CLK;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge CLK);
		$display("Timeout: the tests did not finish within %0d clock cycles", WATCHDOG_CYCLES);
		stop_run();
	end

	function automatic free_count_t model_free_count();
		free_count_t n;
		n = '0;
		for (int i = 0; i < CHECKPOINT_COUNT; i++) begin
			n = n + free_count_t'(!model_busy[i]);
		end
		return n;
	endfunction

	// 0 when the array is full
	function automatic checkpoint_index_t model_lowest_free();
		for (int i = 0; i < CHECKPOINT_COUNT; i++) begin
			if (!model_busy[i]) return checkpoint_index_t'(i);
		end
		return '0;
	endfunction

	task automatic new_snapshot();
		rng_state = xorshift(rng_state);
		snap_map[31:0] = rng_state;
		rng_state = xorshift(rng_state);
		snap_map[47:32] = rng_state[15:0];
		snap_lh = rng_state[23:16];
		rng_state = xorshift(rng_state);
		snap_gh = rng_state[11:0];
		snap_ras = rng_state[14:12];
	endtask

	task automatic check_status();
		check_flag(last_save_ready, model_free_count() != 0, "save ready");
		check_index(last_save_index, model_lowest_free(), "save index");
		check_flag(last_above_threshold, model_free_count() > CHECKPOINT_THRESHOLD, "threshold flag");
	endtask

	// save slot is picked before the clear frees anything
	task automatic save_clear(input logic save, input logic clear, input checkpoint_index_t idx);
		checkpoint_index_t slot;
		slot = model_lowest_free();
		if (save && !model_busy[slot]) begin
			model_busy[slot] = 1'b1;
			model_map[slot] = snap_map;
			model_lh[slot] = snap_lh;
			model_gh[slot] = snap_gh;
			model_ras[slot] = snap_ras;
		end
		if (clear) model_busy[idx] = 1'b0;
		pulse_strobes(save, clear, idx);
		check_status();
	endtask

	task automatic check_restore(input checkpoint_index_t mt_idx, input checkpoint_index_t bi_idx);
		drive_restore(mt_idx, bi_idx);
		check_map_table(last_map_table_restore_map_table, model_map[mt_idx], "restored map table");
		check_lh(last_branch_info_restore_LH, model_lh[bi_idx], "restored local history");
		check_gh(last_branch_info_restore_GH, model_gh[bi_idx], "restored global history");
		check_ras(last_branch_info_restore_ras_index, model_ras[bi_idx], "restored RAS index");
	endtask

	// ----------------------------------------
	// directed tests
	task automatic test_after_reset();
		repeat (2) @(negedge CLK);
		check_flag(last_save_ready, 1'b1, "ready after reset");
		check_index(last_save_index, 3'd0, "index after reset");
		check_flag(last_above_threshold, 1'b1, "threshold flag after reset");
	endtask

	task automatic test_save_restore();
		new_snapshot();
		save_clear(1'b1, 1'b0, 3'd0);
		check_restore(3'd0, 3'd0);
		save_clear(1'b0, 1'b1, 3'd0);
	endtask

	// ninth strobe on a full array must not disturb anything
	task automatic test_fill();
		for (int i = 0; i < CHECKPOINT_COUNT; i++) begin
			check_index(last_save_index, checkpoint_index_t'(i), "fill order");
			new_snapshot();
			save_clear(1'b1, 1'b0, 3'd0);
		end
		check_flag(last_save_ready, 1'b0, "ready when full");
		new_snapshot();
		save_clear(1'b1, 1'b0, 3'd0);
		for (int i = 0; i < CHECKPOINT_COUNT; i++) begin
			check_restore(checkpoint_index_t'(i), checkpoint_index_t'(i));
		end
	endtask

	task automatic test_clear_reuse();
		save_clear(1'b0, 1'b1, 3'd5);
		save_clear(1'b0, 1'b1, 3'd2);
		check_index(last_save_index, 3'd2, "index after clears");
		check_flag(last_save_ready, 1'b1, "ready after clears");
		new_snapshot();
		save_clear(1'b1, 1'b0, 3'd0);
		check_index(last_save_index, 3'd5, "index after reuse");
		check_restore(3'd2, 3'd2);
		new_snapshot();
		save_clear(1'b1, 1'b1, 3'd7);
		check_index(last_save_index, 3'd7, "index after save with clear");
		check_restore(3'd5, 3'd5);
	endtask

	task automatic test_independent_reads();
		check_restore(3'd3, 3'd6);
		check_restore(3'd6, 3'd1);
	endtask

	initial begin
		rng_state = SEED;
		model_busy = '0;
		idle_inputs();
		nRST = 1'b0;
		repeat (4) @(posedge CLK);
		@(negedge CLK);
		nRST = 1'b1;
		test_after_reset();
		test_save_restore();
		test_fill();
		test_clear_reuse();
		test_independent_reads();
		$display("Verification passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+testbench
verilog/checkpoint_pkg.sv
verilog/checkpoint_alloc.sv
verilog/checkpoint_storage.sv
verilog/checkpoint_array.sv
verilog/checkpoint_array_wrapper.sv
testbench/checkpoint_array_tb.sv

//--- Bender.yml
package:
  name: checkpoint_array

sources:
  - verilog/checkpoint_pkg.sv
  - verilog/checkpoint_alloc.sv
  - verilog/checkpoint_storage.sv
  - verilog/checkpoint_array.sv
  - verilog/checkpoint_array_wrapper.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/checkpoint_array_tb.sv
